/* filelist.f */
src/video_pkg.sv
src/filter_pkg.sv
src/window_if.sv
src/line_window.sv
src/blur_kernel.sv
src/edge_detector.sv
src/blur_region_select.sv
src/face_blur_top.sv
dv/face_blur_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the face blur testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module face_blur_tb -f filelist.f -o sim_face_blur

./obj_dir/sim_face_blur > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"

/* dv/face_blur_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module face_blur_tb;

    localparam int frame_pixels = video_pkg::image_width * video_pkg::image_height;
    // Five frames of 76800 pixels plus the random valid gaps
    localparam int max_cycles   = 400000;
    // Tap (0,0) lies four lines and seven pixels behind the accepted pixel
    localparam int window_back  = 4 * video_pkg::image_width + 7;
    localparam int cut_pixels   = 110 * video_pkg::image_width;
    localparam logic [11:0] dark_pix   = 12'h222;
    localparam logic [11:0] bright_pix = 12'heee;

    logic        clk;
    logic        rst_n;
    logic        ready;
    logic        valid;
    logic        startofpacket_in;
    logic        endofpacket_in;
    logic [11:0] data_in;
    logic [11:0] data_out;
    logic        out_valid;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    logic [11:0] frame_mem   [frame_pixels];
    logic [11:0] out_mem     [frame_pixels];
    logic [11:0] gapless_mem [frame_pixels];

    face_blur_top uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .ready            (ready),
        .valid            (valid),
        .startofpacket_in (startofpacket_in),
        .endofpacket_in   (endofpacket_in),
        .data_in          (data_in),
        .data_out         (data_out),
        .out_valid        (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
            $display("Test FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, expected);
            $display("Test FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // Blur of pixel n from the frame array with zeros before the frame start
    function automatic logic [11:0] model_blur(input int n);
        int          sum [3];
        int          norm [3];
        int          mixed [3];
        int          m;
        int          k;
        logic [11:0] tap;
        logic        bright;
        for (int c = 0; c < 3; c++) begin
            sum[c] = 0;
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 7; j++) begin
                k   = i * 7 + j;
                m   = n - window_back + i * video_pkg::image_width + j;
                tap = (m < 0) ? 12'h000 : frame_mem[m];
                if (filter_pkg::blur_shift[k] != 4'd15) begin
                    for (int c = 0; c < 3; c++) begin
                        sum[c] += int'((tap >> (8 - 4 * c)) & 12'hf) << filter_pkg::blur_shift[k];
                    end
                end
            end
        end
        bright = 1'b1;
        for (int c = 0; c < 3; c++) begin
            norm[c] = sum[c] / 64;
            bright  = bright && (norm[c] > filter_pkg::bright_level);
        end
        for (int c = 0; c < 3; c++) begin
            mixed[c] = norm[c];
            if (bright) begin
                mixed[c] = (norm[c] + int'((frame_mem[n] >> (8 - 4 * c)) & 12'hf)) / 2;
            end
        end
        return {4'(mixed[0]), 4'(mixed[1]), 4'(mixed[2])};
    endfunction

    // One accepted pixel whose result is registered at the next edge
    task automatic send_pixel(input logic [11:0] pix, input logic sof, input logic eop,
                              output logic [11:0] result);
        ready            = 1'b1;
        valid            = 1'b1;
        data_in          = pix;
        startofpacket_in = sof;
        endofpacket_in   = eop;
        @(negedge clk);
        check_value(out_valid, 1, "out_valid after an accepted pixel");
        result           = data_out;
        valid            = 1'b0;
        startofpacket_in = 1'b0;
        endofpacket_in   = 1'b0;
    endtask

    // Idle cycles where ready and valid are never high together
    task automatic idle_cycles(input int count);
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            rnd     = xorshift32();
            ready   = rnd[1];
            valid   = rnd[0] && !rnd[1];
            data_in = rnd[15:4];
            @(negedge clk);
            check_value(out_valid, 0, "out_valid without an accept");
        end
    endtask

    task automatic stream_frame(input int count, input bit with_gaps);
        logic [11:0] result;
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            if (with_gaps) begin
                rnd = xorshift32();
                if (rnd[2:0] == 3'd0) begin
                    idle_cycles(1 + rnd[3]);
                end
            end
            send_pixel(frame_mem[n], n == 0, n == count - 1, result);
            out_mem[n] = result;
        end
    endtask

    task automatic fill_uniform(input logic [11:0] colour);
        for (int n = 0; n < frame_pixels; n++) begin
            frame_mem[n] = colour;
        end
    endtask

    // Dark frame with a 40x40 bright square near the centre
    // Bright bar on the top two rows gives edges only above the first head row
    task automatic fill_square();
        int r;
        int c;
        bit in_square;
        bit in_bar;
        for (int n = 0; n < frame_pixels; n++) begin
            r = n / video_pkg::image_width;
            c = n % video_pkg::image_width;
            in_square    = r >= 100 && r < 140 && c >= 140 && c < 180;
            in_bar       = r < 2 && c >= 150 && c < 170;
            frame_mem[n] = (in_square || in_bar) ? bright_pix : dark_pix;
        end
    endtask

    task automatic expect_passthrough(input string what);
        for (int n = 0; n < frame_pixels; n++) begin
            check_value(out_mem[n], frame_mem[n], $sformatf("%s, pixel %0d", what, n));
        end
    endtask

    task automatic check_idle_after_reset();
        valid = 1'b0;
        for (int n = 0; n < 3; n++) begin
            @(negedge clk);
            check_value(out_valid, 0, "out_valid after reset");
            check_value(data_out, 0, "data_out after reset");
        end
    endtask

    task automatic run_uniform_frame();
        logic [31:0] rnd;
        rnd = xorshift32();
        fill_uniform(rnd[11:0]);
        stream_frame(frame_pixels, 0);
        expect_passthrough("uniform frame");
    endtask

    task automatic run_square_frame();
        int r;
        int c;
        bit changed;
        changed = 0;
        fill_square();
        stream_frame(frame_pixels, 0);
        for (int n = 0; n < frame_pixels; n++) begin
            r = n / video_pkg::image_width;
            c = n % video_pkg::image_width;
            gapless_mem[n] = out_mem[n];
            if (r < filter_pkg::first_row || c < filter_pkg::min_col) begin
                check_value(out_mem[n], frame_mem[n], $sformatf("edge zone pixel %0d", n));
            end else if (out_mem[n] !== frame_mem[n]) begin
                changed = 1;
                check_value(out_mem[n], model_blur(n), $sformatf("blurred pixel %0d", n));
            end
        end
        check_value(changed, 1, "square frame has blurred pixels");
    endtask

    task automatic replay_square_with_gaps();
        fill_square();
        stream_frame(frame_pixels, 1);
        for (int n = 0; n < frame_pixels; n++) begin
            check_value(out_mem[n], gapless_mem[n], $sformatf("gapped replay pixel %0d", n));
        end
    endtask

    // Frame cut while the tracker follows the square and then a clean uniform frame
    task automatic restart_mid_frame();
        logic [31:0] rnd;
        fill_square();
        stream_frame(cut_pixels, 0);
        rnd = xorshift32();
        fill_uniform(rnd[11:0]);
        stream_frame(frame_pixels, 0);
        expect_passthrough("frame after restart");
    endtask

    initial begin
        rng_state        = 32'h016d_6ab0;
        rst_n            = 1'b0;
        ready            = 1'b0;
        valid            = 1'b0;
        startofpacket_in = 1'b0;
        endofpacket_in   = 1'b0;
        data_in          = 12'h000;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        check_idle_after_reset();
        run_uniform_frame();
        run_square_frame();
        replay_square_with_gaps();
        restart_mid_frame();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* src/face_blur_top.sv */
`timescale 1ns/100ps
`default_nettype none

module face_blur_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ready,
    input  logic                          valid,
    input  logic                          startofpacket_in,
    input  logic                          endofpacket_in,
    input  logic [video_pkg::pixel_w-1:0] data_in,
    output logic [video_pkg::pixel_w-1:0] data_out,
    output logic                          out_valid
);

    // End of packet is part of the bus but the frame size is fixed
    video_pkg::pixel_u pix_in;
    video_pkg::pixel_u blur_pix;
    video_pkg::pixel_u pix_out;
    logic              edge_flag;

    window_if win ();

    assign pix_in.raw = data_in;
    assign data_out   = pix_out.raw;

    line_window u_line_window (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid   (valid),
        .ready   (ready),
        .sof     (startofpacket_in),
        .data_in (pix_in),
        .win     (win.source)
    );

    blur_kernel u_blur_kernel (
        .win      (win.kernel),
        .blur_pix (blur_pix)
    );

    edge_detector u_edge_detector (
        .win       (win.kernel),
        .edge_flag (edge_flag)
    );

    blur_region_select u_blur_region_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win.track),
        .edge_flag (edge_flag),
        .blur_pix  (blur_pix),
        .data_out  (pix_out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

/* src/blur_region_select.sv */
`timescale 1ns/100ps
`default_nettype none

module blur_region_select (
    input  logic              clk,
    input  logic              rst_n,
    window_if.track           win,
    input  logic              edge_flag,
    input  video_pkg::pixel_u blur_pix,
    output video_pkg::pixel_u data_out,
    output logic              out_valid
);

    logic [1:0]                  state_q;
    logic [1:0]                  state_now;
    logic [video_pkg::col_w-1:0] span_lo_q;
    logic [video_pkg::col_w-1:0] span_hi_q;
    logic [video_pkg::col_w-1:0] rec_lo_q;
    logic [video_pkg::col_w-1:0] rec_hi_q;
    logic                        rec_any_q;
    logic [video_pkg::col_w-1:0] rec_lo_d;
    logic [video_pkg::col_w-1:0] rec_hi_d;
    logic                        rec_any_d;
    logic                        frame_start;
    logic                        line_end;
    logic                        in_band;
    logic                        in_span;
    logic                        head_hit;
    logic                        track_hit;
    logic                        blur_sel;

    assign frame_start = (win.col == '0) && (win.row == '0);
    assign line_end    = (win.col == video_pkg::image_width - 1);

    // Every frame starts over with a fresh head search
    assign state_now = frame_start ? filter_pkg::trk_search : state_q;

    assign in_band = (win.col >= filter_pkg::centre_col - filter_pkg::search_half)
                  && (win.col <= filter_pkg::centre_col + filter_pkg::search_half);

    // Previous row's span, widened on both sides
    assign in_span = (win.col + filter_pkg::span_margin >= span_lo_q)
                  && (win.col <= span_hi_q + filter_pkg::span_margin);

    assign head_hit  = (state_now == filter_pkg::trk_search) && edge_flag
                    && (win.row >= filter_pkg::first_row) && in_band;
    assign track_hit = (state_now == filter_pkg::trk_track)
                    && (win.col >= filter_pkg::min_col) && in_span;
    assign blur_sel  = head_hit || track_hit;

    // First and last edge columns seen on this row
    always_comb begin
        rec_lo_d  = rec_lo_q;
        rec_hi_d  = rec_hi_q;
        rec_any_d = rec_any_q;
        if (head_hit) begin
            rec_lo_d  = win.col;
            rec_hi_d  = win.col;
            rec_any_d = 1'b1;
        end else if (track_hit && edge_flag) begin
            if (!rec_any_q) begin
                rec_lo_d = win.col;
            end
            rec_hi_d  = win.col;
            rec_any_d = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= filter_pkg::trk_search;
            span_lo_q <= '0;
            span_hi_q <= '0;
            rec_lo_q  <= '0;
            rec_hi_q  <= '0;
            rec_any_q <= 1'b0;
            data_out  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= win.accept;
            if (win.accept) begin
                data_out  <= blur_sel ? blur_pix : win.cur;
                state_q   <= state_now;
                rec_lo_q  <= rec_lo_d;
                rec_hi_q  <= rec_hi_d;
                rec_any_q <= rec_any_d;
                case (state_now)
                    filter_pkg::trk_search: begin
                        if (head_hit) begin
                            state_q   <= filter_pkg::trk_track;
                            span_lo_q <= win.col;
                            span_hi_q <= win.col;
                        end
                    end
                    filter_pkg::trk_track: begin
                        // Next row follows the edges found on this one
                        if (line_end) begin
                            rec_any_q <= 1'b0;
                            if (rec_any_d) begin
                                span_lo_q <= rec_lo_d;
                                span_hi_q <= rec_hi_d;
                            end else begin
                                state_q <= filter_pkg::trk_done;
                            end
                        end
                    end
                    default: begin
                        state_q <= filter_pkg::trk_done;
                    end
                endcase
            end
        end
    end

    // Tracking never carries a span back above the first head row
    blur_below_first_row: assert property (@(posedge clk) disable iff (!rst_n)
        (win.accept && blur_sel) |-> (win.row >= filter_pkg::first_row))
        else $error("blur selected above the first head row");

endmodule

`default_nettype wire

/* src/edge_detector.sv */
`timescale 1ns/100ps
`default_nettype none

module edge_detector (
    window_if.kernel win,
    output logic     edge_flag
);

    logic signed [9:0]  ttob_sum [video_pkg::num_chan];
    logic signed [9:0]  ltor_sum [video_pkg::num_chan];
    logic signed [9:0]  term;
    logic signed [16:0] ttob_grey;
    logic signed [16:0] ltor_grey;

    // Weighted greyscale of three signed channel sums
    function automatic logic signed [16:0] grey(input logic signed [9:0] r,
                                                input logic signed [9:0] g,
                                                input logic signed [9:0] b);
        logic signed [16:0] r_x;
        logic signed [16:0] g_x;
        logic signed [16:0] b_x;
        r_x = r;
        g_x = g;
        b_x = b;
        return (r_x <<< filter_pkg::grey_r_shift)
             + (g_x <<< filter_pkg::grey_g_shift)
             + (b_x <<< filter_pkg::grey_b_shift);
    endfunction

    always_comb begin
        int k;
        term = '0;
        for (int c = 0; c < video_pkg::num_chan; c++) begin
            ttob_sum[c] = '0;
            ltor_sum[c] = '0;
            for (int i = 0; i < filter_pkg::win_rows; i++) begin
                for (int j = 0; j < filter_pkg::edge_cols; j++) begin
                    k    = i * filter_pkg::edge_cols + j;
                    term = 10'(video_pkg::channel(win.taps[i][j], c));

                    // Upper rows count up, lower rows count down
                    if (filter_pkg::ttob_shift[k] != filter_pkg::blank_shift) begin
                        if (i < filter_pkg::win_rows / 2) begin
                            ttob_sum[c] = ttob_sum[c] + (term <<< filter_pkg::ttob_shift[k]);
                        end else begin
                            ttob_sum[c] = ttob_sum[c] - (term <<< filter_pkg::ttob_shift[k]);
                        end
                    end

                    // Left columns count up, right columns count down
                    if (filter_pkg::ltor_shift[k] != filter_pkg::blank_shift) begin
                        if (j < filter_pkg::edge_cols / 2) begin
                            ltor_sum[c] = ltor_sum[c] + (term <<< filter_pkg::ltor_shift[k]);
                        end else begin
                            ltor_sum[c] = ltor_sum[c] - (term <<< filter_pkg::ltor_shift[k]);
                        end
                    end
                end
            end
        end
        ttob_grey = grey(ttob_sum[0], ttob_sum[1], ttob_sum[2]);
        ltor_grey = grey(ltor_sum[0], ltor_sum[1], ltor_sum[2]);
    end

    // Kernels lean negative so flat areas give no edge
    assign edge_flag = (ttob_grey > 0) || (ltor_grey > 0);

endmodule

`default_nettype wire

/* src/blur_kernel.sv */
`timescale 1ns/100ps
`default_nettype none

module blur_kernel (
    window_if.kernel          win,
    output video_pkg::pixel_u blur_pix
);

    logic [9:0] sum  [video_pkg::num_chan];
    logic [3:0] norm [video_pkg::num_chan];
    logic [4:0] pair [video_pkg::num_chan];
    logic [3:0] held [video_pkg::num_chan];
    logic       bright;

    always_comb begin
        int k;
        for (int c = 0; c < video_pkg::num_chan; c++) begin
            sum[c] = '0;
            for (int i = 0; i < filter_pkg::win_rows; i++) begin
                for (int j = 0; j < filter_pkg::win_cols; j++) begin
                    k = i * filter_pkg::win_cols + j;
                    if (filter_pkg::blur_shift[k] != filter_pkg::blank_shift) begin
                        sum[c] = sum[c] + (10'(video_pkg::channel(win.taps[i][j], c))
                                 << filter_pkg::blur_shift[k]);
                    end
                end
            end
            // Weights add up to 64 so the top four bits are the mean
            norm[c] = sum[c][9:6];
        end

        // Bright areas are pulled back towards the current pixel
        bright = (norm[0] > filter_pkg::bright_level)
              && (norm[1] > filter_pkg::bright_level)
              && (norm[2] > filter_pkg::bright_level);

        for (int c = 0; c < video_pkg::num_chan; c++) begin
            pair[c] = {1'b0, norm[c]} + {1'b0, video_pkg::channel(win.cur, c)};
            held[c] = bright ? pair[c][4:1] : norm[c];
        end

        blur_pix.rgb.red   = held[0];
        blur_pix.rgb.green = held[1];
        blur_pix.rgb.blue  = held[2];
    end

endmodule

`default_nettype wire

/* src/line_window.sv */
`timescale 1ns/100ps
`default_nettype none

module line_window (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid,
    input  logic              ready,
    input  logic              sof,
    input  video_pkg::pixel_u data_in,
    window_if.source          win
);

    video_pkg::pixel_u           line_q [filter_pkg::buf_depth];
    logic [video_pkg::col_w-1:0] col_q;
    logic [video_pkg::row_w-1:0] row_q;
    logic [video_pkg::col_w-1:0] col_now;
    logic [video_pkg::col_w-1:0] col_nxt;
    logic [video_pkg::row_w-1:0] row_now;
    logic [video_pkg::row_w-1:0] row_nxt;
    logic                        accept;

    assign accept = valid && ready;

    // Start of packet makes this pixel the new frame's pixel 0
    assign col_now = sof ? '0 : col_q;
    assign row_now = sof ? '0 : row_q;

    always_comb begin
        col_nxt = col_now + 1'b1;
        row_nxt = row_now;
        if (col_now == video_pkg::image_width - 1) begin
            col_nxt = '0;
            if (row_now == video_pkg::image_height - 1) begin
                row_nxt = '0;
            end else begin
                row_nxt = row_now + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
            for (int k = 0; k < filter_pkg::buf_depth; k++) begin
                line_q[k] <= '0;
            end
        end else if (accept) begin
            col_q <= col_nxt;
            row_q <= row_nxt;
            // Oldest pixel drops out at index 0
            for (int k = 0; k < filter_pkg::buf_depth - 1; k++) begin
                line_q[k] <= sof ? '0 : line_q[k + 1];
            end
            line_q[filter_pkg::buf_depth - 1] <= data_in;
        end else if (sof) begin
            col_q <= '0;
            row_q <= '0;
            for (int k = 0; k < filter_pkg::buf_depth; k++) begin
                line_q[k] <= '0;
            end
        end
    end

    // Window taps, all zero for a frame's first pixel
    always_comb begin
        for (int i = 0; i < filter_pkg::win_rows; i++) begin
            for (int j = 0; j < filter_pkg::win_cols; j++) begin
                win.taps[i][j] = sof ? '0 : line_q[i * video_pkg::image_width + j];
            end
        end
    end

    assign win.col    = col_now;
    assign win.row    = row_now;
    assign win.accept = accept;
    assign win.cur    = data_in;

    col_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        col_q < video_pkg::image_width)
        else $error("column counter left the line");

endmodule

`default_nettype wire

/* src/window_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface window_if;

    // Tap (i,j) lies 4 lines plus 7 pixels back, moved on by i lines and j pixels
    video_pkg::pixel_u           taps [filter_pkg::win_rows][filter_pkg::win_cols];

    // Position and value of the pixel being accepted
    logic [video_pkg::col_w-1:0] col;
    logic [video_pkg::row_w-1:0] row;
    logic                        accept;
    video_pkg::pixel_u           cur;

    modport source (output taps, output col, output row, output accept, output cur);
    modport kernel (input taps, input cur);
    modport track  (input col, input row, input accept, input cur);

endinterface

`default_nettype wire

/* src/filter_pkg.sv */
`default_nettype none

package filter_pkg;

    // Blur window shape, edge kernels use its leftmost columns
    localparam int win_rows  = 5;
    localparam int win_cols  = 7;
    localparam int edge_cols = 5;

    // Four full lines plus the partial line that closes the window
    localparam int buf_depth = 4 * video_pkg::image_width + win_cols;

    // Shift value of an empty tap
    localparam logic [3:0] blank_shift = 4'd15;

    // Blur weights as left shifts, row 0 first, weights add up to 64
    localparam logic [3:0] blur_shift [win_rows*win_cols] = '{
        15, 0, 0, 0, 1, 1, 1,
        15, 0, 0, 1, 1, 1, 1,
         0, 0, 1, 1, 1, 1, 1,
         0, 1, 1, 1, 1, 1, 2,
         1, 1, 1, 1, 1, 2, 2
    };

    // Top half adds and bottom half subtracts, middle row is empty
    localparam logic [3:0] ttob_shift [win_rows*edge_cols] = '{
         0,  0,  1,  1,  2,
         0,  0,  1,  1,  1,
        15, 15, 15, 15, 15,
         1,  1,  1,  1,  1,
         1,  1,  1,  1,  2
    };

    // Left half adds and right half subtracts, middle column is empty
    localparam logic [3:0] ltor_shift [win_rows*edge_cols] = '{
        0, 0, 15, 1, 1,
        0, 0, 15, 1, 1,
        1, 1, 15, 1, 1,
        1, 1, 15, 1, 1,
        2, 1, 15, 1, 2
    };

    // Greyscale weights 32, 64 and 16
    localparam int grey_r_shift = 5;
    localparam int grey_g_shift = 6;
    localparam int grey_b_shift = 4;

    // Head search and span tracking
    localparam int centre_col   = 162;
    localparam int search_half  = 30;
    localparam int first_row    = 6;
    localparam int span_margin  = 5;
    localparam int min_col      = 7;
    localparam int bright_level = 10;

    // Tracker states
    localparam logic [1:0] trk_search = 2'd0;
    localparam logic [1:0] trk_track  = 2'd1;
    localparam logic [1:0] trk_done   = 2'd2;

endpackage

`default_nettype wire

/* src/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Frame format is fixed at 320x240
    localparam int image_width  = 320;
    localparam int image_height = 240;

    // Position counters
    localparam int col_w = 9;
    localparam int row_w = 8;

    // Pixel word and channel count
    localparam int pixel_w  = 12;
    localparam int num_chan = 3;

    // RGB444 with red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // Bus word on the ports, channel fields inside the kernels
    typedef union packed {
        logic [pixel_w-1:0] raw;
        rgb_t               rgb;
    } pixel_u;

    // Channel c of a pixel, 0 is red and 2 is blue
    function automatic logic [3:0] channel(input pixel_u p, input int c);
        logic [3:0] v;
        case (c)
            0:       v = p.rgb.red;
            1:       v = p.rgb.green;
            default: v = p.rgb.blue;
        endcase
        return v;
    endfunction

endpackage

`default_nettype wire
